// ==== include/gcn_config.svh ====
`ifndef GCN_CONFIG_SVH
`define GCN_CONFIG_SVH

// graph dimensions
`define GCN_NUM_NODES   6
`define GCN_NUM_EDGES   6   // edge slots per job

// data widths
`define GCN_FEAT_W      5   // one feature element
`define GCN_SUM_W       10  // holds six full-scale elements

// feature memory
`define GCN_NUM_PAIRS   4   // two columns read per pair
`define GCN_ADDR_W      7

// output flow control
`define GCN_MAX_CREDITS 4   // receiver buffer depth after reset

`endif

// ==== hdl/gcn_pkg.sv ====
`default_nettype none

`include "gcn_config.svh"

package gcn_pkg;

    // job sequencing
    typedef enum logic [2:0] {
        IDLE,
        BUILD,
        FETCH,
        AGG,
        DONE
    } gcn_state_t;

    typedef logic [2:0] node_t;  // 0 marks an unused edge slot

    typedef logic [`GCN_FEAT_W-1:0] feat_t;

    // element i belongs to node i
    typedef feat_t [`GCN_NUM_NODES-1:0] feat_col_t;

    typedef logic [`GCN_SUM_W-1:0] sum_t;

    // bit j set when node j is a neighbour
    typedef logic [`GCN_NUM_NODES-1:0] adj_row_t;

    typedef logic [`GCN_ADDR_W-1:0] fm_addr_t;

    typedef logic [$clog2(`GCN_NUM_PAIRS)-1:0] pair_t;

endpackage

`default_nettype wire

// ==== hdl/gcn_ctrl.sv ====
`default_nettype none

`include "gcn_config.svh"

module gcn_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           build_done,
    input  logic           cols_ready,
    input  logic           pair_done,
    input  logic           tx_idle,
    output logic           build_en,
    output logic           fetch_req,
    output logic           agg_start,
    output logic           done,
    output gcn_pkg::pair_t pair
);

    gcn_pkg::gcn_state_t state, state_nxt;
    logic                last_pair;

    assign last_pair = (pair == gcn_pkg::pair_t'(`GCN_NUM_PAIRS - 1));

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            gcn_pkg::IDLE: begin
                if (start) state_nxt = gcn_pkg::BUILD;
            end
            gcn_pkg::BUILD: begin
                if (build_done) state_nxt = gcn_pkg::FETCH;
            end
            gcn_pkg::FETCH: begin
                if (cols_ready) state_nxt = gcn_pkg::AGG;
            end
            gcn_pkg::AGG: begin
                if (pair_done) state_nxt = last_pair ? gcn_pkg::DONE : gcn_pkg::FETCH;
            end
            gcn_pkg::DONE: begin
                if (tx_idle) state_nxt = gcn_pkg::IDLE;  // last result has left
            end
            default: state_nxt = gcn_pkg::IDLE;
        endcase
    end

    assign build_en  = (state == gcn_pkg::BUILD);
    assign agg_start = (state == gcn_pkg::FETCH) && cols_ready;  // columns land this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= gcn_pkg::IDLE;
            pair      <= '0;
            fetch_req <= 1'b0;
            done      <= 1'b0;
        end else begin
            state <= state_nxt;
            // one read request on every entry into FETCH
            fetch_req <= ((state == gcn_pkg::BUILD) && build_done) ||
                         ((state == gcn_pkg::AGG) && pair_done && !last_pair);
            done      <= (state == gcn_pkg::DONE) && tx_idle;
            if ((state == gcn_pkg::IDLE) && start) begin
                pair <= '0;
            end else if ((state == gcn_pkg::AGG) && pair_done && !last_pair) begin
                pair <= pair + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/adj_builder.sv ====
`default_nettype none

`include "gcn_config.svh"

module adj_builder (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  gcn_pkg::node_t   [`GCN_NUM_EDGES-1:0] edge_a,
    input  gcn_pkg::node_t   [`GCN_NUM_EDGES-1:0] edge_b,
    input  logic                                   build_en,
    output logic                                   build_done,
    output gcn_pkg::adj_row_t [`GCN_NUM_NODES-1:0] adj_rows
);

    localparam int SLOT_W = $clog2(`GCN_NUM_EDGES);

    gcn_pkg::node_t [`GCN_NUM_EDGES-1:0] edge_a_r;
    gcn_pkg::node_t [`GCN_NUM_EDGES-1:0] edge_b_r;
    logic [SLOT_W-1:0]                   slot;
    gcn_pkg::node_t                      cur_a, cur_b;
    gcn_pkg::node_t                      row_a, row_b;
    logic                                slot_ok;

    assign cur_a = edge_a_r[slot];
    assign cur_b = edge_b_r[slot];

    // node 0 and anything past the last node leave the matrix alone
    assign slot_ok = (cur_a != '0) && (cur_a <= `GCN_NUM_NODES) &&
                     (cur_b != '0) && (cur_b <= `GCN_NUM_NODES);

    assign row_a = cur_a - 3'd1;  // node numbers are 1 based
    assign row_b = cur_b - 3'd1;

    assign build_done = build_en && (slot == SLOT_W'(`GCN_NUM_EDGES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (start || build_done) begin
            slot <= '0;
        end else if (build_en) begin
            slot <= slot + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // edge list and matrix
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (start) begin
            edge_a_r <= edge_a;
            edge_b_r <= edge_b;
            adj_rows <= '0;  // fresh matrix for every job
        end else if (build_en && slot_ok) begin
            adj_rows[row_a][row_b] <= 1'b1;
            adj_rows[row_b][row_a] <= 1'b1;  // same bit when a == b
        end
    end

endmodule

`default_nettype wire

// ==== hdl/feat_fetch.sv ====
`default_nettype none

`include "gcn_config.svh"

module feat_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_req,
    input  gcn_pkg::pair_t      pair,
    output logic                fm_re,
    output gcn_pkg::fm_addr_t   fm_addr0,
    output gcn_pkg::fm_addr_t   fm_addr1,
    input  gcn_pkg::feat_col_t  fm_rdata0,
    input  gcn_pkg::feat_col_t  fm_rdata1,
    output gcn_pkg::feat_col_t  col0,
    output gcn_pkg::feat_col_t  col1,
    output logic                cols_ready
);

    logic rd_pending;  // read data is on the bus this cycle

    //////////////////////////////////////////////////
    // read strobe
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_re      <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            fm_re      <= fetch_req;
            rd_pending <= fm_re;  // memory answers one cycle later
        end
    end

    // columns are captured at the end of this cycle
    assign cols_ready = rd_pending;

    // pair p reads columns 2p and 2p+1
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fm_addr0 <= gcn_pkg::fm_addr_t'({pair, 1'b0});
            fm_addr1 <= gcn_pkg::fm_addr_t'({pair, 1'b1});
        end
    end

    // holding registers stay put for the whole pair
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            col0 <= fm_rdata0;
            col1 <= fm_rdata1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/node_aggregator.sv ====
`default_nettype none

`include "gcn_config.svh"

module node_aggregator (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   agg_start,
    input  gcn_pkg::adj_row_t [`GCN_NUM_NODES-1:0] adj_rows,
    input  gcn_pkg::feat_col_t                     col0,
    input  gcn_pkg::feat_col_t                     col1,
    input  gcn_pkg::pair_t                         pair,
    input  logic                                   tx_ready,
    output logic                                   agg_valid,
    output gcn_pkg::node_t                         agg_node,
    output gcn_pkg::pair_t                         agg_pair,
    output gcn_pkg::sum_t                          agg_sum0,
    output gcn_pkg::sum_t                          agg_sum1,
    output logic                                   pair_done
);

    localparam gcn_pkg::node_t LAST_NODE = gcn_pkg::node_t'(`GCN_NUM_NODES - 1);

    logic              run;        // node index stage holds a node
    gcn_pkg::node_t    idx;
    logic              adv;
    gcn_pkg::adj_row_t mask;
    gcn_pkg::sum_t     sum0_nxt, sum1_nxt;

    assign adv  = !agg_valid || tx_ready;  // output stage free or draining
    assign mask = adj_rows[idx];

    // neighbour sum for both columns
    always_comb begin
        sum0_nxt = '0;
        sum1_nxt = '0;
        for (int i = 0; i < `GCN_NUM_NODES; i++) begin
            if (mask[i]) begin
                sum0_nxt = sum0_nxt + gcn_pkg::sum_t'(col0[i]);
                sum1_nxt = sum1_nxt + gcn_pkg::sum_t'(col1[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run       <= 1'b0;
            idx       <= '0;
            agg_valid <= 1'b0;
        end else begin
            if (agg_start) begin
                run <= 1'b1;
                idx <= '0;
            end else if (run && adv) begin
                run <= (idx != LAST_NODE);
                idx <= (idx == LAST_NODE) ? '0 : idx + 1'b1;
            end
            if (adv) agg_valid <= run;
        end
    end

    // result registers tagged with node and pair
    always_ff @(posedge clk) begin
        if (run && adv) begin
            agg_node <= idx;
            agg_pair <= pair;
            agg_sum0 <= sum0_nxt;
            agg_sum1 <= sum1_nxt;
        end
    end

    assign pair_done = agg_valid && tx_ready && (agg_node == LAST_NODE);

endmodule

`default_nettype wire

// ==== hdl/credit_tx.sv ====
`default_nettype none

`include "gcn_config.svh"

module credit_tx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           agg_valid,
    input  gcn_pkg::node_t agg_node,
    input  gcn_pkg::pair_t agg_pair,
    input  gcn_pkg::sum_t  agg_sum0,
    input  gcn_pkg::sum_t  agg_sum1,
    output logic           tx_ready,
    output logic           tx_idle,
    input  logic           out_credit,
    output logic           out_valid,
    output gcn_pkg::node_t out_node,
    output gcn_pkg::pair_t out_pair,
    output gcn_pkg::sum_t  out_sum0,
    output gcn_pkg::sum_t  out_sum1
);

    localparam int CREDIT_W = $clog2(`GCN_MAX_CREDITS + 1);

    logic                full;        // output register holds a result
    logic [CREDIT_W-1:0] credit_cnt;
    logic                load;

    assign out_valid = full && (credit_cnt != '0);  // no credit, no beat
    assign tx_ready  = !full || out_valid;
    assign tx_idle   = !full;
    assign load      = agg_valid && tx_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full       <= 1'b0;
            credit_cnt <= CREDIT_W'(`GCN_MAX_CREDITS);
        end else begin
            if (load) begin
                full <= 1'b1;
            end else if (out_valid) begin
                full <= 1'b0;
            end
            // spend and return may land in the same cycle
            credit_cnt <= credit_cnt - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_node <= agg_node;
            out_pair <= agg_pair;
            out_sum0 <= agg_sum0;
            out_sum1 <= agg_sum1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gcn_top.sv ====
`default_nettype none

`include "gcn_config.svh"

module gcn_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  gcn_pkg::node_t [`GCN_NUM_EDGES-1:0] edge_a,
    input  gcn_pkg::node_t [`GCN_NUM_EDGES-1:0] edge_b,
    output logic                                 fm_re,
    output gcn_pkg::fm_addr_t                    fm_addr0,
    output gcn_pkg::fm_addr_t                    fm_addr1,
    input  gcn_pkg::feat_col_t                   fm_rdata0,
    input  gcn_pkg::feat_col_t                   fm_rdata1,
    output logic                                 out_valid,
    output gcn_pkg::node_t                       out_node,
    output gcn_pkg::pair_t                       out_pair,
    output gcn_pkg::sum_t                        out_sum0,
    output gcn_pkg::sum_t                        out_sum1,
    input  logic                                 out_credit,
    output logic                                 done
);

    logic                                   build_en, build_done;
    logic                                   fetch_req, cols_ready;
    logic                                   agg_start, pair_done;
    logic                                   tx_idle, tx_ready;
    logic                                   agg_valid;
    gcn_pkg::pair_t                         pair, agg_pair;
    gcn_pkg::node_t                         agg_node;
    gcn_pkg::sum_t                          agg_sum0, agg_sum1;
    gcn_pkg::feat_col_t                     col0, col1;
    gcn_pkg::adj_row_t [`GCN_NUM_NODES-1:0] adj_rows;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    gcn_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start),
        .build_done(build_done), .cols_ready(cols_ready),
        .pair_done(pair_done), .tx_idle(tx_idle),
        .build_en(build_en), .fetch_req(fetch_req),
        .agg_start(agg_start), .done(done), .pair(pair)
    );

    // edge list is taken with start, so start stays low while a job runs
    adj_builder u_adj (
        .clk(clk), .rst_n(rst_n), .start(start),
        .edge_a(edge_a), .edge_b(edge_b),
        .build_en(build_en), .build_done(build_done), .adj_rows(adj_rows)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    feat_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .pair(pair),
        .fm_re(fm_re), .fm_addr0(fm_addr0), .fm_addr1(fm_addr1),
        .fm_rdata0(fm_rdata0), .fm_rdata1(fm_rdata1),
        .col0(col0), .col1(col1), .cols_ready(cols_ready)
    );

    node_aggregator u_agg (
        .clk(clk), .rst_n(rst_n), .agg_start(agg_start),
        .adj_rows(adj_rows), .col0(col0), .col1(col1), .pair(pair),
        .tx_ready(tx_ready), .agg_valid(agg_valid),
        .agg_node(agg_node), .agg_pair(agg_pair),
        .agg_sum0(agg_sum0), .agg_sum1(agg_sum1), .pair_done(pair_done)
    );

    credit_tx u_tx (
        .clk(clk), .rst_n(rst_n), .agg_valid(agg_valid),
        .agg_node(agg_node), .agg_pair(agg_pair),
        .agg_sum0(agg_sum0), .agg_sum1(agg_sum1),
        .tx_ready(tx_ready), .tx_idle(tx_idle), .out_credit(out_credit),
        .out_valid(out_valid), .out_node(out_node), .out_pair(out_pair),
        .out_sum0(out_sum0), .out_sum1(out_sum1)
    );

endmodule

`default_nettype wire

// ==== verif/gcn_checker.sv ====
`default_nettype none

`include "gcn_config.svh"

module gcn_checker (
    input logic                                     clk,
    input logic                                     rst_n,
    input logic                                     out_valid,
    input logic                                     full,
    input logic [$clog2(`GCN_MAX_CREDITS + 1)-1:0]  credit_cnt,
    input gcn_pkg::node_t                           out_node,
    input gcn_pkg::pair_t                           out_pair,
    input gcn_pkg::sum_t                            out_sum0,
    input gcn_pkg::sum_t                            out_sum1
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;  // seen by the testbench

    // a beat always spends a held credit
    a_valid_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (credit_cnt != '0)
    ) else begin
        fail_cnt++;
        $error("out_valid with zero credits");
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) credit_cnt <= `GCN_MAX_CREDITS
    ) else begin
        fail_cnt++;
        $error("credit count above the receiver limit");
    end

    // stalled result stays in the register untouched
    a_hold_without_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (full && credit_cnt == '0) |=> full && $stable({out_node, out_pair, out_sum0, out_sum1})
    ) else begin
        fail_cnt++;
        $error("output register changed while no credit was held");
    end

endmodule

`default_nettype wire

// ==== verif/gcn_tb.sv ====
`default_nettype none

`include "gcn_config.svh"

module gcn_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NODES    = `GCN_NUM_NODES;
    localparam int EDGES    = `GCN_NUM_EDGES;
    localparam int BEATS    = `GCN_NUM_NODES * `GCN_NUM_PAIRS;
    localparam int NUM_JOBS = 5;
    // build, then per pair a fetch overhead and up to 8 cycles per node
    localparam int MAX_CYCLES = NUM_JOBS * (EDGES + `GCN_NUM_PAIRS * (3 + NODES * 8)) + 200;

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    gcn_pkg::node_t [EDGES-1:0]  edge_a, edge_b;
    logic                        fm_re;
    gcn_pkg::fm_addr_t           fm_addr0, fm_addr1;
    gcn_pkg::feat_col_t          fm_rdata0, fm_rdata1;
    logic                        out_valid;
    gcn_pkg::node_t              out_node;
    gcn_pkg::pair_t              out_pair;
    gcn_pkg::sum_t               out_sum0, out_sum1;
    logic                        out_credit;
    logic                        done;

    gcn_pkg::feat_col_t          mem [0:(1 << `GCN_ADDR_W) - 1];
    gcn_pkg::node_t [EDGES-1:0]  job_a, job_b;  // edge list of the running job
    gcn_pkg::fm_addr_t           rd_addr0, rd_addr1;
    logic [31:0]                 rng, crd_rng;
    string                       test_name;
    logic                        job_active, slow_credit;
    int beat = 0;
    int done_cnt = 0;
    int fetch_cnt = 0;
    int owed = 0;                               // results not yet credited back
    int cycles = 0;

    gcn_top dut (
        .clk(clk), .rst_n(rst_n), .start(start), .edge_a(edge_a), .edge_b(edge_b),
        .fm_re(fm_re), .fm_addr0(fm_addr0), .fm_addr1(fm_addr1),
        .fm_rdata0(fm_rdata0), .fm_rdata1(fm_rdata1),
        .out_valid(out_valid), .out_node(out_node), .out_pair(out_pair),
        .out_sum0(out_sum0), .out_sum1(out_sum1), .out_credit(out_credit), .done(done)
    );

    bind credit_tx gcn_checker u_checker (
        .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .full(full),
        .credit_cnt(credit_cnt), .out_node(out_node), .out_pair(out_pair),
        .out_sum0(out_sum0), .out_sum1(out_sum1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected neighbour sum of one node over one feature column
    function automatic gcn_pkg::sum_t ref_sum(input int node, input gcn_pkg::fm_addr_t col);
        logic [NODES-1:0] nbr;
        gcn_pkg::sum_t    acc;
        nbr = '0;
        acc = '0;
        for (int s = 0; s < EDGES; s++) begin
            if (job_a[s] != 0 && job_a[s] <= NODES && job_b[s] != 0 && job_b[s] <= NODES) begin
                if (job_a[s] == node + 1) nbr[job_b[s] - 1] = 1'b1;
                if (job_b[s] == node + 1) nbr[job_a[s] - 1] = 1'b1;  // self loop lands once
            end
        end
        for (int j = 0; j < NODES; j++) begin
            if (nbr[j]) acc = acc + gcn_pkg::sum_t'(mem[col][j]);
        end
        return acc;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_sum(input string what, input gcn_pkg::sum_t exp,
                             input gcn_pkg::sum_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_node(input string what, input gcn_pkg::node_t exp,
                              input gcn_pkg::node_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pair(input string what, input gcn_pkg::pair_t exp,
                              input gcn_pkg::pair_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input gcn_pkg::fm_addr_t exp,
                              input gcn_pkg::fm_addr_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < (1 << `GCN_ADDR_W); a++) begin
            for (int j = 0; j < NODES; j++) begin
                rng = xorshift32(rng);
                mem[a][j] = rng[`GCN_FEAT_W-1:0];
            end
        end
    endtask

    task automatic random_edges(input logic valid_only);
        for (int s = 0; s < EDGES; s++) begin
            rng = xorshift32(rng);
            if (valid_only) begin
                job_a[s] = gcn_pkg::node_t'(rng[7:0] % NODES + 1);
                job_b[s] = gcn_pkg::node_t'(rng[15:8] % NODES + 1);
            end else begin
                job_a[s] = rng[2:0];  // 0 and 7 show up as unused slots
                job_b[s] = rng[10:8];
            end
        end
    endtask

    task automatic run_job(input string name, input logic slow);
        test_name   = name;
        slow_credit = slow;
        fill_memory();
        beat       = 0;
        done_cnt   = 0;
        fetch_cnt  = 0;
        edge_a     = job_a;
        edge_b     = job_b;
        start      = 1'b1;
        job_active = 1'b1;
        next_cycle(1);
        start = 1'b0;
        // scramble the inputs since the DUT keeps its own copy
        rng    = xorshift32(rng);
        edge_a = rng[17:0];
        rng    = xorshift32(rng);
        edge_b = rng[17:0];
        while (done_cnt == 0) next_cycle(1);
        next_cycle(3);
        if (done_cnt != 1) begin
            $display("done pulsed %0d times in %s", done_cnt, name);
            abort_run();
        end
        job_active = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // memory model, credit receiver, compare
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && fm_re) begin
            check_addr("fm_addr0", gcn_pkg::fm_addr_t'(2 * fetch_cnt), fm_addr0);
            check_addr("fm_addr1", gcn_pkg::fm_addr_t'(2 * fetch_cnt + 1), fm_addr1);
            fetch_cnt++;
            rd_addr0 = fm_addr0;
            rd_addr1 = fm_addr1;
            #1;
            fm_rdata0 = mem[rd_addr0];  // one cycle after the strobe
            fm_rdata1 = mem[rd_addr1];
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) owed = owed + 1;
        if (owed > `GCN_MAX_CREDITS) begin
            $display("%0d results outstanding, more than the credit limit", owed);
            abort_run();
        end
        crd_rng = xorshift32(crd_rng);
        #1;
        if (owed > 0 && (!slow_credit || crd_rng[1:0] == 2'b00)) begin
            out_credit = 1'b1;
            owed       = owed - 1;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(posedge clk) begin : compare
        int n;
        int p;
        n = beat % NODES;
        p = beat / NODES;
        if (rst_n) begin
            if (!job_active && (fm_re || out_valid || done)) begin
                $display("DUT active with no job started, fm_re=%b out_valid=%b done=%b",
                         fm_re, out_valid, done);
                abort_run();
            end
            if (out_valid) begin
                if (beat >= BEATS) begin
                    $display("more than %0d results in %s", BEATS, test_name);
                    abort_run();
                end
                check_node("node", gcn_pkg::node_t'(n), out_node);
                check_pair("pair", gcn_pkg::pair_t'(p), out_pair);
                check_sum("sum0", ref_sum(n, gcn_pkg::fm_addr_t'(2 * p)), out_sum0);
                check_sum("sum1", ref_sum(n, gcn_pkg::fm_addr_t'(2 * p + 1)), out_sum1);
                beat++;
            end
            if (done) begin
                if (beat != BEATS) begin
                    $display("done pulsed after %0d of %0d results", beat, BEATS);
                    abort_run();
                end
                done_cnt++;
            end
            if (dut.u_tx.u_checker.fail_cnt != 0) begin
                $display("an assertion on the credit output failed");
                abort_run();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, jobs not finished after %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // job sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        edge_a      = '0;
        edge_b      = '0;
        fm_rdata0   = '0;
        fm_rdata1   = '0;
        out_credit  = 1'b0;
        job_active  = 1'b0;
        slow_credit = 1'b0;
        rng         = 32'h0c45dac3;
        crd_rng     = 32'h0c45dac3;
        test_name   = "reset_state";
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle(5);  // outputs stay low with no start

        random_edges(1'b1);
        run_job("random_graph", 1'b0);

        // edges (1,7) (2,6) (5,0) (4,4) (7,2) (0,3) from slot 5 down to slot 0
        job_a = {3'd1, 3'd2, 3'd5, 3'd4, 3'd7, 3'd0};
        job_b = {3'd7, 3'd6, 3'd0, 3'd4, 3'd2, 3'd3};
        run_job("unused_slots", 1'b0);

        random_edges(1'b0);
        run_job("back_pressure", 1'b1);

        random_edges(1'b1);
        run_job("back_to_back_dense", 1'b0);
        job_a = {3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd1};  // only edge (1,2)
        job_b = {3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd2};
        run_job("back_to_back_sparse", 1'b1);

        if (dut.u_tx.u_checker.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            abort_run();
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hdl/gcn_pkg.sv
hdl/gcn_ctrl.sv
hdl/adj_builder.sv
hdl/feat_fetch.sv
hdl/node_aggregator.sv
hdl/credit_tx.sv
hdl/gcn_top.sv
verif/gcn_checker.sv
verif/gcn_tb.sv

// ==== Bender.yml ====
package:
  name: gcn_agg

sources:
  - include_dirs:
      - include
    files:
      - hdl/gcn_pkg.sv
      - hdl/gcn_ctrl.sv
      - hdl/adj_builder.sv
      - hdl/feat_fetch.sv
      - hdl/node_aggregator.sv
      - hdl/credit_tx.sv
      - hdl/gcn_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/gcn_checker.sv
      - verif/gcn_tb.sv
